//--- include/snd_consts.svh
// constants for the sound back end; widths match the snd_pkg types they feed
// register offsets are byte offsets on a 4-bit AXI4-Lite address

`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// register map
`define SND_REG_CTRL    4'h0
`define SND_REG_STAT    4'h4

// 4.4 gains, 8'h10 is unity
`define SND_FM_GAIN     8'h06
`define SND_PCM_GAIN_0  8'h04   // fxlevel 0
`define SND_PCM_GAIN_1  8'h08
`define SND_PCM_GAIN_2  8'h0C
`define SND_PCM_GAIN_3  8'h10   // fxlevel 3, unity

// pole coefficients as a fraction of 128
`define SND_POLE_LO     7'd104
`define SND_POLE_HI     7'd108

// AXI4-Lite response codes
`define SND_RESP_OKAY   2'd0
`define SND_RESP_SLVERR 2'd2

`endif

//--- verilog/snd_pkg.sv
// types shared by the sound back end and its testbench
// AXI4-Lite address is only 4 bits wide, enough for the two registers

package snd_pkg;

    typedef logic signed [15:0] sample_t;   // FM input and mixer output
    typedef logic signed [13:0] pcm_t;      // raw ADPCM sample
    typedef logic        [7:0]  gain_t;     // 4.4 unsigned
    typedef logic        [6:0]  pole_coef_t; // fraction of 128

    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    typedef struct packed {
        gain_t      fm_gain;
        gain_t      pcm_gain;
        logic       filter_en;
        pole_coef_t pole_a;
    } snd_cfg_t;

    // master to slave
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic [3:0] wstrb;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

//--- verilog/snd_regs.sv
// AXI4-Lite control block: CTRL at 0x0, sticky clip flag in STAT at 0x4
// only wstrb[0] is honoured, other offsets answer SLVERR

`include "snd_consts.svh"

module snd_regs (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::axil_req_t bus_req,
    output snd_pkg::axil_rsp_t bus_rsp,
    input  logic               clip,
    output snd_pkg::snd_cfg_t  cfg
);

    logic [5:0]          ctrl;      // pole_sel, filter_en, fxlevel, pcm_en, fm_en
    logic [5:0]          ctrl_nxt;
    logic                clip_flag;
    logic                wr_take;
    logic                rd_take;
    logic                wr_mapped;
    logic                rd_mapped;
    logic                wr_ctrl;
    logic                wr_stat;
    logic                bvalid;
    logic                rvalid;
    snd_pkg::axil_resp_t bresp;
    snd_pkg::axil_resp_t rresp;
    snd_pkg::axil_data_t rdata;
    snd_pkg::axil_data_t rd_word;
    snd_pkg::gain_t      pcm_gain_nxt;

    // one outstanding response per channel
    assign wr_take = bus_req.awvalid & bus_req.wvalid & ~bvalid;
    assign rd_take = bus_req.arvalid & ~rvalid;

    assign wr_mapped = (bus_req.awaddr == `SND_REG_CTRL) || (bus_req.awaddr == `SND_REG_STAT);
    assign rd_mapped = (bus_req.araddr == `SND_REG_CTRL) || (bus_req.araddr == `SND_REG_STAT);

    assign wr_ctrl = wr_take && bus_req.wstrb[0] && (bus_req.awaddr == `SND_REG_CTRL);
    assign wr_stat = wr_take && bus_req.wstrb[0] && (bus_req.awaddr == `SND_REG_STAT);

    // decode from the next value so cfg follows a write by one cycle
    assign ctrl_nxt = wr_ctrl ? bus_req.wdata[5:0] : ctrl;

    always_comb begin
        case (ctrl_nxt[3:2])
            2'd0:    pcm_gain_nxt = `SND_PCM_GAIN_0;
            2'd1:    pcm_gain_nxt = `SND_PCM_GAIN_1;
            2'd2:    pcm_gain_nxt = `SND_PCM_GAIN_2;
            default: pcm_gain_nxt = `SND_PCM_GAIN_3;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl          <= '0;
            cfg.fm_gain   <= '0;
            cfg.pcm_gain  <= '0;
            cfg.filter_en <= 1'b0;
            cfg.pole_a    <= `SND_POLE_LO;
        end else begin
            ctrl          <= ctrl_nxt;
            cfg.fm_gain   <= ctrl_nxt[0] ? `SND_FM_GAIN : 8'h00;
            cfg.pcm_gain  <= ctrl_nxt[1] ? pcm_gain_nxt : 8'h00;
            cfg.filter_en <= ctrl_nxt[4];
            cfg.pole_a    <= ctrl_nxt[5] ? `SND_POLE_HI : `SND_POLE_LO;
        end
    end

    // set beats clear when both land together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clip_flag <= 1'b0;
        end else if (clip) begin
            clip_flag <= 1'b1;
        end else if (wr_stat && bus_req.wdata[0]) begin
            clip_flag <= 1'b0;
        end
    end

    // write response channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= `SND_RESP_OKAY;
        end else if (wr_take) begin
            bvalid <= 1'b1;
            bresp  <= wr_mapped ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
        end else if (bus_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_comb begin
        case (bus_req.araddr)
            `SND_REG_CTRL: rd_word = {26'd0, ctrl};
            `SND_REG_STAT: rd_word = {31'd0, clip_flag};
            default:       rd_word = '0;   // unmapped reads as zero
        endcase
    end

    // read data channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= `SND_RESP_OKAY;
        end else if (rd_take) begin
            rvalid <= 1'b1;
            rresp  <= rd_mapped ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
        end else if (bus_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata <= rd_word;
        end
    end

    always_comb begin
        bus_rsp.awready = wr_take;   // single-cycle pulse
        bus_rsp.wready  = wr_take;
        bus_rsp.bvalid  = bvalid;
        bus_rsp.bresp   = bresp;
        bus_rsp.arready = rd_take;
        bus_rsp.rvalid  = rvalid;
        bus_rsp.rdata   = rdata;
        bus_rsp.rresp   = rresp;
    end

endmodule

//--- verilog/snd_pole.sv
// one-pole low-pass on the ADPCM stream, output changes only on pcm_valid
// state advances only while the filter is enabled

module snd_pole (
    input  logic                clk,
    input  logic                rst,
    input  snd_pkg::pcm_t       pcm_in,
    input  logic                pcm_valid,
    input  logic                filter_en,
    input  snd_pkg::pole_coef_t pole_a,
    output snd_pkg::sample_t    pole_out
);

    snd_pkg::pcm_t      state;
    snd_pkg::pcm_t      state_nxt;
    logic signed [14:0] diff;     // pcm_in - state can need a 15th bit
    logic signed [8:0]  weight;   // 128 - pole_a, 1 to 128
    logic signed [23:0] prod;
    logic signed [23:0] step;

    assign diff   = pcm_in - state;
    assign weight = 9'sd128 - $signed({2'b00, pole_a});
    assign prod   = diff * weight;
    assign step   = prod >>> 7;

    // true result lies between state and pcm_in, so the 14-bit wrap is harmless
    assign state_nxt = state + $signed(step[13:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= '0;
            pole_out <= '0;
        end else if (pcm_valid) begin
            if (filter_en) begin
                state    <= state_nxt;
                pole_out <= {state_nxt, 2'b00};
            end else begin
                pole_out <= {pcm_in, 2'b00};   // bypass, same latency
            end
        end
    end

endmodule

//--- verilog/snd_mixer.sv
// one output channel: two sources with 4.4 gains, registered result
// peak flags the cycle in which the 16-bit clamp acted

module snd_mixer (
    input  logic             clk,
    input  logic             rst,
    input  snd_pkg::sample_t ch_a,
    input  snd_pkg::sample_t ch_b,
    input  snd_pkg::gain_t   gain_a,
    input  snd_pkg::gain_t   gain_b,
    output snd_pkg::sample_t mixed,
    output logic             peak
);

    logic signed [24:0] prod_a;
    logic signed [24:0] prod_b;
    logic signed [25:0] sum;
    logic signed [21:0] scaled;   // sum >>> 4
    logic               over;
    logic               under;

    // gains are unsigned, so give them a zero sign bit
    assign prod_a = ch_a * $signed({1'b0, gain_a});
    assign prod_b = ch_b * $signed({1'b0, gain_b});
    assign sum    = prod_a + prod_b;
    assign scaled = sum[25:4];

    assign over  = scaled > 22'sd32767;
    assign under = scaled < -22'sd32768;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else begin
            if (over) begin
                mixed <= 16'sh7fff;
            end else if (under) begin
                mixed <= 16'sh8000;
            end else begin
                mixed <= scaled[15:0];
            end
            peak <= over | under;
        end
    end

endmodule

//--- verilog/snd_top.sv
// sound back end: FM stereo plus filtered ADPCM mono, mixed to 16-bit stereo
// no clock enable, every input sample is taken on the cycle it is valid

module snd_top (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::axil_req_t bus_req,
    output snd_pkg::axil_rsp_t bus_rsp,
    input  snd_pkg::sample_t   fm_left,
    input  snd_pkg::sample_t   fm_right,
    input  logic               fm_valid,
    input  snd_pkg::pcm_t      pcm_in,
    input  logic               pcm_valid,
    output snd_pkg::sample_t   left,
    output snd_pkg::sample_t   right,
    output logic               out_valid,
    output logic               peak
);

    snd_pkg::snd_cfg_t cfg;
    snd_pkg::sample_t  pole_out;   // ADPCM, padded to 16 bits
    logic              peak_l;
    logic              peak_r;

    assign peak = peak_l | peak_r;   // also sets the sticky clip flag

    // mixers add one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fm_valid;
        end
    end

    snd_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .clip    (peak),
        .cfg     (cfg)
    );

    snd_pole u_pole (
        .clk       (clk),
        .rst       (rst),
        .pcm_in    (pcm_in),
        .pcm_valid (pcm_valid),
        .filter_en (cfg.filter_en),
        .pole_a    (cfg.pole_a),
        .pole_out  (pole_out)
    );

    snd_mixer u_mix_l (
        .clk    (clk),
        .rst    (rst),
        .ch_a   (fm_left),
        .ch_b   (pole_out),
        .gain_a (cfg.fm_gain),
        .gain_b (cfg.pcm_gain),
        .mixed  (left),
        .peak   (peak_l)
    );

    snd_mixer u_mix_r (
        .clk    (clk),
        .rst    (rst),
        .ch_a   (fm_right),
        .ch_b   (pole_out),   // mono ADPCM on both sides
        .gain_a (cfg.fm_gain),
        .gain_b (cfg.pcm_gain),
        .mixed  (right),
        .peak   (peak_r)
    );

endmodule

//--- test/snd_chk.sv
// concurrent checks bound into snd_top from the testbench
// shadow models follow the register map, the one-pole rule and the 4.4 mix

`include "snd_consts.svh"

module snd_chk (
    input logic               clk,
    input logic               rst,
    input snd_pkg::axil_req_t bus_req,
    input snd_pkg::axil_rsp_t bus_rsp,
    input snd_pkg::snd_cfg_t  cfg,
    input snd_pkg::sample_t   fm_left,
    input snd_pkg::sample_t   fm_right,
    input logic               fm_valid,
    input snd_pkg::pcm_t      pcm_in,
    input logic               pcm_valid,
    input snd_pkg::sample_t   pole_out,
    input snd_pkg::sample_t   left,
    input snd_pkg::sample_t   right,
    input logic               out_valid,
    input logic               peak
);

    int unsigned         fails = 0;   // read back by the testbench
    logic [5:0]          ctrl_m;
    logic                clip_m;
    snd_pkg::pcm_t       state_m;
    snd_pkg::pcm_t       state_nx;
    snd_pkg::sample_t    pole_m;
    logic [16:0]         exp_l;       // {clamped, sample}
    logic [16:0]         exp_r;
    logic [31:0]         rdata_m;
    logic [1:0]          rresp_m;
    logic [1:0]          bresp_m;
    snd_pkg::gain_t      fm_g;
    snd_pkg::gain_t      pcm_g;
    snd_pkg::pole_coef_t coef;
    logic                wr_take;
    logic                rd_take;

    function automatic snd_pkg::pcm_t pole_rule(input snd_pkg::pcm_t x, input snd_pkg::pcm_t s,
                                                input snd_pkg::pole_coef_t a);
        int d;
        int k;
        d = int'(x) - int'(s);
        k = 128 - int'(a);
        return s + 14'((d * k) >>> 7);   // wraps at 14 bits
    endfunction

    function automatic logic [16:0] mix_rule(input snd_pkg::sample_t a, input snd_pkg::sample_t b,
                                             input snd_pkg::gain_t ga, input snd_pkg::gain_t gb);
        int acc;
        acc = (int'(a) * int'(ga) + int'(b) * int'(gb)) >>> 4;
        if (acc > 32767)
            return {1'b1, 16'h7fff};
        if (acc < -32768)
            return {1'b1, 16'h8000};
        return {1'b0, acc[15:0]};
    endfunction

    task automatic flag_fail(input string what);
        $error("%s", what);
        fails++;
    endtask

    assign wr_take  = bus_req.awvalid && bus_req.wvalid && !bus_rsp.bvalid;
    assign rd_take  = bus_req.arvalid && !bus_rsp.rvalid;
    assign fm_g     = ctrl_m[0] ? `SND_FM_GAIN : 8'h00;
    assign pcm_g    = !ctrl_m[1] ? 8'h00 :
                      ctrl_m[3] ? (ctrl_m[2] ? `SND_PCM_GAIN_3 : `SND_PCM_GAIN_2) :
                                  (ctrl_m[2] ? `SND_PCM_GAIN_1 : `SND_PCM_GAIN_0);
    assign coef     = ctrl_m[5] ? `SND_POLE_HI : `SND_POLE_LO;
    assign state_nx = pole_rule(pcm_in, state_m, coef);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_m  <= '0;
            clip_m  <= 1'b0;
            state_m <= '0;
            pole_m  <= '0;
            exp_l   <= '0;
            exp_r   <= '0;
        end else begin
            if (wr_take && bus_req.wstrb[0] && bus_req.awaddr == `SND_REG_CTRL) begin
                ctrl_m <= bus_req.wdata[5:0];
            end
            if (peak) begin
                clip_m <= 1'b1;
            end else if (wr_take && bus_req.wstrb[0] && bus_req.awaddr == `SND_REG_STAT &&
                         bus_req.wdata[0]) begin
                clip_m <= 1'b0;
            end
            if (pcm_valid && ctrl_m[4]) begin
                state_m <= state_nx;
                pole_m  <= {state_nx, 2'b00};
            end else if (pcm_valid) begin
                pole_m <= {pcm_in, 2'b00};   // bypass
            end
            exp_l <= mix_rule(fm_left, pole_m, fm_g, pcm_g);
            exp_r <= mix_rule(fm_right, pole_m, fm_g, pcm_g);
        end
    end

    // expected bus responses captured when the request is taken
    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp_m <= (bus_req.awaddr == `SND_REG_CTRL || bus_req.awaddr == `SND_REG_STAT) ?
                       `SND_RESP_OKAY : `SND_RESP_SLVERR;
        end
        if (rd_take) begin
            case (bus_req.araddr)
                `SND_REG_CTRL: rdata_m <= {26'd0, ctrl_m};
                `SND_REG_STAT: rdata_m <= {31'd0, clip_m};
                default:       rdata_m <= 32'd0;
            endcase
            rresp_m <= (bus_req.araddr == `SND_REG_CTRL || bus_req.araddr == `SND_REG_STAT) ?
                       `SND_RESP_OKAY : `SND_RESP_SLVERR;
        end
    end

    a_cfg: assert property (@(posedge clk) disable iff (rst) cfg == {fm_g, pcm_g, ctrl_m[4], coef})
        else flag_fail("cfg does not follow the CTRL decode");
    a_pole: assert property (@(posedge clk) disable iff (rst) pole_out == pole_m)
        else flag_fail("pole_out differs from the one-pole model");
    a_left: assert property (@(posedge clk) disable iff (rst) left == exp_l[15:0])
        else flag_fail("left differs from the mix model");
    a_right: assert property (@(posedge clk) disable iff (rst) right == exp_r[15:0])
        else flag_fail("right differs from the mix model");
    a_peak: assert property (@(posedge clk) disable iff (rst) peak == (exp_l[16] | exp_r[16]))
        else flag_fail("peak does not match the clamp cycles");
    a_valid: assert property (@(posedge clk) disable iff (rst) 1'b1 |=> out_valid == $past(fm_valid))
        else flag_fail("out_valid is not fm_valid one cycle later");
    a_ready: assert property (@(posedge clk) disable iff (rst)
                              bus_rsp.awready == wr_take && bus_rsp.wready == wr_take &&
                              bus_rsp.arready == rd_take)
        else flag_fail("ready pulses do not match the accepted requests");
    a_bresp: assert property (@(posedge clk) disable iff (rst)
                              bus_rsp.bvalid |-> bus_rsp.bresp == bresp_m)
        else flag_fail("wrong write response");
    a_rdata: assert property (@(posedge clk) disable iff (rst)
                              bus_rsp.rvalid |->
                              bus_rsp.rdata == rdata_m && bus_rsp.rresp == rresp_m)
        else flag_fail("wrong read data or read response");
    a_bhold: assert property (@(posedge clk) disable iff (rst)
                              bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid)
        else flag_fail("bvalid dropped before bready");
    a_rhold: assert property (@(posedge clk) disable iff (rst)
                              bus_rsp.rvalid && !bus_req.rready |=> bus_rsp.rvalid)
        else flag_fail("rvalid dropped before rready");
    a_reset: assert property (@(posedge clk) rst |=> !bus_rsp.bvalid && !bus_rsp.rvalid &&
                              !out_valid && !peak && left == 16'sd0 && right == 16'sd0)
        else flag_fail("outputs not cleared by reset");

endmodule

//--- test/snd_tb.sv
// testbench for snd_top; the bound snd_chk assertions do most of the checking
// register read-back and reset values are also compared here

`include "snd_consts.svh"

module snd_tb;

    localparam int LIMIT = 100;   // cycles per wait

    logic               clk = 1'b0;
    logic               rst;
    snd_pkg::axil_req_t bus_req;
    snd_pkg::axil_rsp_t bus_rsp;
    snd_pkg::sample_t   fm_left;
    snd_pkg::sample_t   fm_right;
    logic               fm_valid;
    snd_pkg::pcm_t      pcm_in;
    logic               pcm_valid;
    snd_pkg::sample_t   left;
    snd_pkg::sample_t   right;
    logic               out_valid;
    logic               peak;
    int                 errs = 0;
    int                 seen = 0;     // failures already charged to a test
    int                 passed = 0;
    int                 failed = 0;
    logic [31:0]        rd;
    logic [31:0]        resp;

    always #10 clk = ~clk;

    snd_top u_dut (.*);

    bind snd_top snd_chk u_chk (
        .clk (clk), .rst (rst), .bus_req (bus_req), .bus_rsp (bus_rsp), .cfg (cfg),
        .fm_left (fm_left), .fm_right (fm_right), .fm_valid (fm_valid),
        .pcm_in (pcm_in), .pcm_valid (pcm_valid), .pole_out (pole_out),
        .left (left), .right (right), .out_valid (out_valid), .peak (peak)
    );

    task automatic abort(input string why);
        $display("timeout waiting for %s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            errs++;
        end
    endtask

    // called and returns just after a rising edge
    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall,
                             output logic [31:0] bresp);
        int n;
        bus_req.awvalid <= 1'b1;
        bus_req.awaddr  <= addr;
        bus_req.wvalid  <= 1'b1;
        bus_req.wdata   <= data;
        bus_req.wstrb   <= strb;
        n = 0;
        @(negedge clk);
        while (!bus_rsp.awready) begin
            n++;
            if (n > LIMIT) abort("awready");
            @(negedge clk);
        end
        @(posedge clk);
        bus_req.awvalid <= 1'b0;
        bus_req.wvalid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bus_rsp.bvalid) begin
            n++;
            if (n > LIMIT) abort("bvalid");
            @(negedge clk);
        end
        bresp = 32'(bus_rsp.bresp);
        repeat (stall + 1) @(posedge clk);   // bvalid must hold meanwhile
        bus_req.bready <= 1'b1;
        @(posedge clk);
        bus_req.bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, input int stall,
                            output logic [31:0] data, output logic [31:0] rresp);
        int n;
        bus_req.arvalid <= 1'b1;
        bus_req.araddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!bus_rsp.arready) begin
            n++;
            if (n > LIMIT) abort("arready");
            @(negedge clk);
        end
        @(posedge clk);
        bus_req.arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bus_rsp.rvalid) begin
            n++;
            if (n > LIMIT) abort("rvalid");
            @(negedge clk);
        end
        data  = bus_rsp.rdata;
        rresp = 32'(bus_rsp.rresp);
        repeat (stall + 1) @(posedge clk);
        bus_req.rready <= 1'b1;
        @(posedge clk);
        bus_req.rready <= 1'b0;
    endtask

    // random samples where full scale picks only the two extremes
    task automatic play(input int cycles, input logic full_scale);
        repeat (cycles) begin
            fm_valid  <= ($urandom & 3) != 0;
            pcm_valid <= ($urandom % 3) == 0;
            if (full_scale) begin
                fm_left  <= (($urandom & 1) != 0) ? 16'sh7fff : 16'sh8000;
                fm_right <= (($urandom & 1) != 0) ? 16'sh7fff : 16'sh8000;
                pcm_in   <= (($urandom & 1) != 0) ? 14'sh1fff : 14'sh2000;
            end else begin
                fm_left  <= 16'($urandom);
                fm_right <= 16'($urandom);
                pcm_in   <= 14'($urandom);
            end
            @(posedge clk);
        end
        fm_valid  <= 1'b0;
        pcm_valid <= 1'b0;
    endtask

    task automatic end_test(input string name);
        int now;
        repeat (2) @(posedge clk);   // let the pipeline drain
        @(negedge clk);
        now = errs + int'(u_dut.u_chk.fails);
        if (now == seen) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail, %0d errors", name, now - seen);
        end
        seen = now;
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(40354));
        rst       = 1'b1;
        bus_req   = '0;
        fm_left   = '0;
        fm_right  = '0;
        fm_valid  = 1'b0;
        pcm_in    = '0;
        pcm_valid = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // stalled responses, unmapped offsets and a write without byte 0
        bus_write(`SND_REG_CTRL, 32'h2b, 4'hf, 2, resp);
        expect_eq("bresp", resp, 32'(`SND_RESP_OKAY));
        bus_read(`SND_REG_CTRL, 3, rd, resp);
        expect_eq("ctrl", rd, 32'h2b);
        bus_write(`SND_REG_CTRL, 32'h15, 4'he, 0, resp);   // must leave CTRL alone
        bus_write(4'h8, 32'h3f, 4'hf, 0, resp);
        expect_eq("bresp", resp, 32'(`SND_RESP_SLVERR));
        bus_read(4'hc, 1, rd, resp);
        expect_eq("rresp", resp, 32'(`SND_RESP_SLVERR));
        expect_eq("rdata", rd, 32'h0);
        bus_read(`SND_REG_CTRL, 0, rd, resp);
        expect_eq("ctrl", rd, 32'h2b);
        end_test("1 register access");

        for (int c = 0; c < 16; c++) begin
            bus_write(`SND_REG_CTRL, 32'(c), 4'hf, 0, resp);   // filter off
            play(12, 1'b0);
        end
        end_test("2 gain decode");

        for (int p = 0; p < 2; p++) begin
            bus_write(`SND_REG_CTRL, 32'h1f | 32'(p << 5), 4'hf, 0, resp);
            play(40, 1'b0);
        end
        end_test("3 filter");

        bus_write(`SND_REG_CTRL, 32'h0f, 4'hf, 0, resp);   // unity pcm gain
        play(40, 1'b1);
        end_test("4 saturation and peak");

        bus_read(`SND_REG_STAT, 0, rd, resp);
        expect_eq("clip", rd, 32'h1);
        fm_left   <= '0;
        fm_right  <= '0;
        pcm_in    <= '0;
        pcm_valid <= 1'b1;
        @(posedge clk);
        pcm_valid <= 1'b0;
        repeat (3) @(posedge clk);
        bus_write(`SND_REG_STAT, 32'h1, 4'hf, 0, resp);
        bus_read(`SND_REG_STAT, 0, rd, resp);
        expect_eq("clip", rd, 32'h0);
        end_test("5 clip flag");

        bus_write(`SND_REG_CTRL, 32'h3f, 4'hf, 0, resp);
        bus_req.awvalid <= 1'b1;   // leave both responses waiting
        bus_req.awaddr  <= `SND_REG_STAT;
        bus_req.wvalid  <= 1'b1;
        bus_req.wdata   <= 32'h0;
        bus_req.arvalid <= 1'b1;
        bus_req.araddr  <= `SND_REG_CTRL;
        @(posedge clk);
        bus_req.awvalid <= 1'b0;
        bus_req.wvalid  <= 1'b0;
        bus_req.arvalid <= 1'b0;
        play(5, 1'b0);
        fm_valid <= 1'b1;   // out_valid would follow it without reset
        rst      <= 1'b1;
        @(negedge clk);
        expect_eq("bvalid", 32'(bus_rsp.bvalid), 32'h0);
        expect_eq("rvalid", 32'(bus_rsp.rvalid), 32'h0);
        expect_eq("out_valid", 32'(out_valid), 32'h0);
        expect_eq("peak", 32'(peak), 32'h0);
        expect_eq("left", 32'(left), 32'h0);
        expect_eq("right", 32'(right), 32'h0);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_eq("out_valid", 32'(out_valid), 32'h0);
        @(posedge clk);
        fm_valid <= 1'b0;
        bus_read(`SND_REG_CTRL, 0, rd, resp);
        expect_eq("ctrl", rd, 32'h0);
        end_test("6 reset");

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
verilog/snd_pkg.sv
verilog/snd_regs.sv
verilog/snd_pole.sv
verilog/snd_mixer.sv
verilog/snd_top.sv
test/snd_chk.sv
test/snd_tb.sv

//--- Makefile
# Verilator build and run of the sound back end testbench

VERILATOR ?= verilator
TOP       ?= snd_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
